/* sim/multiAdderStim.txt */
// count, operands 0 to 7, expected sum modulo 2^32, all hex
// operands past the count are placeholders, the testbench fills them with random words
0 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
1 12345678 00000000 00000000 00000000 00000000 00000000 00000000 00000000 12345678
2 00000001 00000002 00000000 00000000 00000000 00000000 00000000 00000000 00000003
3 00000010 00000020 00000030 00000000 00000000 00000000 00000000 00000000 00000060
4 11111111 22222222 33333333 44444444 00000000 00000000 00000000 00000000 aaaaaaaa
5 00000001 00000001 00000001 00000001 00000001 00000000 00000000 00000000 00000005
6 10000000 20000000 30000000 40000000 50000000 60000000 00000000 00000000 50000000
7 00000100 00000200 00000300 00000400 00000500 00000600 00000700 00000000 00001c00
8 00000001 00000002 00000003 00000004 00000005 00000006 00000007 00000008 00000024
2 ffffffff 00000001 00000000 00000000 00000000 00000000 00000000 00000000 00000000
8 ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff fffffff8
3 ffffffff ffffffff ffffffff 00000000 00000000 00000000 00000000 00000000 fffffffd
4 80000000 80000000 80000000 80000000 00000000 00000000 00000000 00000000 00000000
5 7fffffff 7fffffff 00000002 00000000 00000001 00000000 00000000 00000000 00000001
6 aaaaaaaa 55555555 aaaaaaaa 55555555 00000001 ffffffff 00000000 00000000 fffffffe
7 0f0f0f0f 0f0f0f0f 0f0f0f0f 0f0f0f0f 0f0f0f0f 0f0f0f0f 0f0f0f0f 00000000 69696969
8 deadbeef 21524111 12345678 87654321 00000001 fffffffe 00000010 00000020 999999c8
f 00000001 00000001 00000001 00000001 00000001 00000001 00000001 00000001 00000008
1 ffffffff 00000000 00000000 00000000 00000000 00000000 00000000 00000000 ffffffff
4 ffff0000 0000ffff 00000001 00000000 00000000 00000000 00000000 00000000 00000000

/* vlog.f */
hw/adderPkg.sv
hw/compressRow.sv
hw/lookaheadAdder.sv
hw/wbRegs.sv
hw/sumSequencer.sv
hw/operandCounter.sv
hw/multiAdderTop.sv
sim/multiAdder_checker.sv
sim/multiAdderTb.sv

/* Makefile */
# Verilator build and run of the multiAdder testbench
TOP := multiAdderTb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f vlog.f -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+100 > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

/* sim/multiAdderTb.sv */
`timescale 1ns/1ns

module multiAdderTb import adderPkg::*; ();

	localparam int NumOps    = 8;
	localparam int LineW     = 10;		// count, 8 operands, expected sum
	localparam int MaxLines  = 64;
	localparam int ClkHalf   = 20;		// 40 ns period
	localparam int RstCycles = 16;

	logic   clk;
	logic   rst;
	wbReq_t wbReq;
	wbRsp_t wbRsp;

	data_t stimMem [LineW*MaxLines];
	int    numLines;
	int    cycleCount = 0;
	int    cycleLimit = 0;		// 0 until the stim file is sized

	multiAdderTop #(.NumOps(NumOps)) dut_i (
		.i_clk(clk),
		.i_rst(rst),
		.i_wbReq(wbReq),
		.o_wbRsp(wbRsp)
	);

	initial clk = 1'b0;
	always #ClkHalf clk = ~clk;

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic checkEq(input data_t actual, input data_t expected, input string what);
		if (actual !== expected) begin
			abortRun($sformatf("mismatch at %0t ns: %s, got %08h, expected %08h",
				$time, what, actual, expected));
		end
	endtask

	// watchdog armed once the stim file is read
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleLimit != 0 && cycleCount > cycleLimit)
			abortRun($sformatf("timeout: test still running after %0d cycles", cycleCount));
	end

	// sticky flag of the bound checker
	always @(negedge clk) begin
		if (dut_i.regs_i.chk_i.anyErr)
			abortRun("a bus or busy timing assertion fired in the checker");
	end

	task automatic waitCycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	// classic write holds the request until ack
	task automatic busWrite(input logic [AddrW-1:0] adr, input data_t dat);
		@(negedge clk);
		wbReq.cyc = 1'b1;
		wbReq.stb = 1'b1;
		wbReq.we  = 1'b1;
		wbReq.adr = adr;
		wbReq.dat = dat;
		@(negedge clk);
		while (!wbRsp.ack)
			@(negedge clk);
		wbReq.cyc = 1'b0;
		wbReq.stb = 1'b0;
		wbReq.we  = 1'b0;
	endtask

	task automatic busRead(input logic [AddrW-1:0] adr, output data_t dat);
		@(negedge clk);
		wbReq.cyc = 1'b1;
		wbReq.stb = 1'b1;
		wbReq.we  = 1'b0;
		wbReq.adr = adr;
		@(negedge clk);
		while (!wbRsp.ack)
			@(negedge clk);
		dat = wbRsp.dat;		// valid with ack
		wbReq.cyc = 1'b0;
		wbReq.stb = 1'b0;
	endtask

	// start pulse comes a cycle after ack, busy one later
	task automatic startRun(input data_t cnt);
		busWrite(AdrCtrl, cnt);
		waitCycles(1);
	endtask

	task automatic waitIdle;
		data_t st;
		busRead(AdrStatus, st);
		while (st[0])
			busRead(AdrStatus, st);
	endtask

	task automatic loadOperands(input int line);
		data_t cnt;
		data_t op;
		int    base;
		base = line * LineW;
		cnt  = stimMem[base];
		for (int i = 0; i < NumOps; i++) begin
			// slots past the count get filler that must not reach the sum
			op = (i < cnt) ? stimMem[base+1+i] : $urandom;
			busWrite(AddrW'(i), op);
		end
	endtask

	task automatic runLine(input int line);
		data_t cnt;
		data_t expSum;
		data_t rd;
		cnt    = stimMem[line*LineW];
		expSum = stimMem[line*LineW+LineW-1];
		loadOperands(line);
		startRun(cnt);
		waitIdle;
		busRead(AdrResult, rd);
		checkEq(rd, expSum, $sformatf("stim line %0d, count %0d", line, cnt));
	endtask

	task automatic loadStim;
		for (int i = 0; i < LineW*MaxLines; i++)
			stimMem[i] = 32'hffff_0000 | 32'(i);	// words the file leaves untouched
		$readmemh("sim/multiAdderStim.txt", stimMem);
		numLines = 0;
		while (numLines < MaxLines && stimMem[numLines*LineW] <= 32'hf)
			numLines++;
		if (numLines == 0)
			abortRun("stim file sim/multiAdderStim.txt is missing or holds no lines");
	endtask

	initial begin : mainFlow
		data_t rd;
		data_t pat [NumOps];
		int    fullLine;
		wbReq = '0;
		rst   = 1'b1;
		void'($urandom(32'hdbaf_d3c6));
		loadStim;
		cycleLimit = numLines * 40 + 200;
		waitCycles(RstCycles);
		rst = 1'b0;

		busRead(AdrStatus, rd);
		checkEq(rd, 32'd0, "status after reset");
		busRead(AdrResult, rd);
		checkEq(rd, 32'd0, "result after reset");

		// operand bank readback
		for (int i = 0; i < NumOps; i++) begin
			pat[i] = $urandom;
			busWrite(AddrW'(i), pat[i]);
		end
		for (int i = 0; i < NumOps; i++) begin
			busRead(AddrW'(i), rd);
			checkEq(rd, pat[i], $sformatf("operand %0d readback", i));
		end

		for (int line = 0; line < numLines; line++)
			runLine(line);

		// a second command while busy must leave the first sum intact
		fullLine = -1;
		for (int line = numLines - 1; line >= 0; line--)
			if (stimMem[line*LineW] == 32'd8)
				fullLine = line;
		if (fullLine < 0)
			abortRun("stim file holds no line with count 8 for the busy test");
		loadOperands(fullLine);
		startRun(32'd8);
		busWrite(AdrCtrl, 32'd2);		// lands early in the compress phase
		busRead(AdrStatus, rd);
		checkEq(rd, 32'd1, "busy during an 8-operand run");
		waitIdle;
		busRead(AdrResult, rd);
		checkEq(rd, stimMem[fullLine*LineW+LineW-1], "ctrl write while busy not ignored");

		waitCycles(2);
		if (!dut_i.regs_i.chk_i.anyErr) begin
			$display("TEST PASSED");
			$finish;
		end else begin
			$display("TEST FAILED");
			$fatal(1, "errors seen during the run");
		end
	end

endmodule

/* sim/multiAdder_checker.sv */
`timescale 1ns/1ns

module multiAdderChecker import adderPkg::*; #(
	parameter int NumOps = 8
) (
	input logic   i_clk,
	input logic   i_rst,
	input wbReq_t i_wbReq,
	input wbRsp_t i_wbRsp,
	input logic   i_busy
);

	int   busyLen;			// busy cycles seen so far
	logic ackHeldErr  = 1'b0;
	logic ackLateErr  = 1'b0;
	logic busyLongErr = 1'b0;
	logic anyErr;

	// sticky, read by the testbench top
	assign anyErr = ackHeldErr | ackLateErr | busyLongErr;

	always_ff @(posedge i_clk) begin
		if (i_rst || !i_busy)
			busyLen <= 0;
		else
			busyLen <= busyLen + 1;
	end

	ackSingle: assert property (@(posedge i_clk) disable iff (i_rst)
		i_wbRsp.ack |=> !i_wbRsp.ack)
		else begin
			ackHeldErr = 1'b1;
			$error("ack high in two consecutive cycles");
		end

	// new request is one not already answered
	ackNext: assert property (@(posedge i_clk) disable iff (i_rst)
		(i_wbReq.cyc && i_wbReq.stb && !i_wbRsp.ack) |=> i_wbRsp.ack)
		else begin
			ackLateErr = 1'b1;
			$error("no ack in the cycle after cyc and stb");
		end

	busyBound: assert property (@(posedge i_clk) disable iff (i_rst)
		busyLen <= NumOps / 2 + 1)
		else begin
			busyLongErr = 1'b1;
			$error("busy high longer than NumOps/2+2 cycles");
		end

endmodule

bind wbRegs multiAdderChecker #(.NumOps(NumOps)) chk_i (
	.i_clk(i_clk),
	.i_rst(i_rst),
	.i_wbReq(i_wbReq),
	.i_wbRsp(o_wbRsp),
	.i_busy(i_busy)
);

/* hw/multiAdderTop.sv */
`timescale 1ns/1ns

module multiAdderTop import adderPkg::*; #(
	parameter int NumOps = 8		// even, 2 .. 8
) (
	input  logic   i_clk,
	input  logic   i_rst,
	input  wbReq_t i_wbReq,
	output wbRsp_t o_wbRsp
);

	localparam int IdxW = $clog2(NumOps);

	logic            busy, accumulate, capture;
	logic            start;
	logic [CntW-1:0] count;
	logic [IdxW-1:0] opIdx;
	logic            hiValid, lastPair, countZero;
	data_t           opLo, opHi;
	data_t           sum;			// resolved accumulator
	csPair_t         csAcc, csNext;

	wbRegs #(.NumOps(NumOps)) regs_i (
		.i_clk(i_clk), .i_rst(i_rst), .i_wbReq(i_wbReq),
		.i_busy(busy), .i_accumulate(accumulate), .i_capture(capture),
		.i_opIdx(opIdx), .i_hiValid(hiValid), .i_csNext(csNext), .i_sum(sum),
		.o_wbRsp(o_wbRsp), .o_start(start), .o_count(count),
		.o_opLo(opLo), .o_opHi(opHi), .o_csAcc(csAcc)
	);

	sumSequencer seq_i (
		.i_clk(i_clk), .i_rst(i_rst), .i_start(start),
		.i_lastPair(lastPair), .i_countZero(countZero),
		.o_busy(busy), .o_accumulate(accumulate), .o_capture(capture)
	);

	operandCounter #(.NumOps(NumOps)) cnt_i (
		.i_clk(i_clk), .i_rst(i_rst), .i_start(start), .i_count(count),
		.i_advance(accumulate),		// counter steps with each compress cycle
		.o_opIdx(opIdx), .o_hiValid(hiValid),
		.o_lastPair(lastPair), .o_countZero(countZero)
	);

	compressRow row_i (.i_acc(csAcc), .i_opLo(opLo), .i_opHi(opHi), .o_next(csNext));

	// final carry-propagate add of the redundant pair
	lookaheadAdder cla_i (.i_a(csAcc.sum), .i_b(csAcc.carry), .o_sum(sum));

endmodule

/* hw/operandCounter.sv */
`timescale 1ns/1ns

module operandCounter import adderPkg::*; #(
	parameter int NumOps = 8
) (
	input  logic                      i_clk,
	input  logic                      i_rst,
	input  logic                      i_start,
	input  logic [CntW-1:0]           i_count,	// already clamped
	input  logic                      i_advance,	// one pair consumed
	output logic [$clog2(NumOps)-1:0] o_opIdx,
	output logic                      o_hiValid,
	output logic                      o_lastPair,
	output logic                      o_countZero
);

	localparam int IdxW = $clog2(NumOps);

	logic [IdxW-1:0] ptr;		// index of the lower word of the pair
	logic [CntW-1:0] remain;	// operands not yet folded in

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			ptr    <= '0;
			remain <= '0;
		end else if (i_start) begin
			ptr    <= '0;
			remain <= i_count;
		end else if (i_advance) begin
			ptr    <= ptr + IdxW'(2);		// wraps after the last pair, unused then
			remain <= (remain >= CntW'(2)) ? remain - CntW'(2) : '0;
		end
	end

	assign o_opIdx    = ptr;
	assign o_hiValid  = remain >= CntW'(2);	// odd tail has no partner
	assign o_lastPair = remain <= CntW'(2);

	// during start the count is not loaded yet, look at it directly
	assign o_countZero = i_start ? (i_count == '0) : (remain == '0);

endmodule

/* hw/sumSequencer.sv */
`timescale 1ns/1ns

module sumSequencer (
	input  logic i_clk,
	input  logic i_rst,
	input  logic i_start,		// one-cycle go from the bus side
	input  logic i_lastPair,	// current pair ends the list
	input  logic i_countZero,	// nothing to compress
	output logic o_busy,
	output logic o_accumulate,	// also steps the operand counter
	output logic o_capture
);

	typedef enum logic [1:0] {
		Idle,
		Compress,
		Resolve
	} state_t;

	state_t state;
	state_t nextState;

	always_comb begin
		nextState = state;
		case (state)
			Idle: begin
				if (i_start)
					nextState = i_countZero ? Resolve : Compress;	// empty list skips ahead
			end
			Compress: begin
				if (i_lastPair)
					nextState = Resolve;
			end
			Resolve: begin
				nextState = Idle;		// one cycle through the final adder
			end
			default: begin
				nextState = Idle;
			end
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_rst)
			state <= Idle;
		else
			state <= nextState;
	end

	// busy spans compress and resolve, drops once result is in
	assign o_busy       = (state != Idle);
	assign o_accumulate = (state == Compress);
	assign o_capture    = (state == Resolve);

endmodule

/* hw/wbRegs.sv */
`timescale 1ns/1ns

module wbRegs import adderPkg::*; #(
	parameter int NumOps = 8
) (
	input  logic                        i_clk,
	input  logic                        i_rst,
	input  wbReq_t                      i_wbReq,
	input  logic                        i_busy,
	input  logic                        i_accumulate,	// load compressor output
	input  logic                        i_capture,		// load adder output
	input  logic [$clog2(NumOps)-1:0]   i_opIdx,
	input  logic                        i_hiValid,
	input  csPair_t                     i_csNext,
	input  data_t                       i_sum,
	output wbRsp_t                      o_wbRsp,
	output logic                        o_start,
	output logic [CntW-1:0]             o_count,
	output data_t                       o_opLo,
	output data_t                       o_opHi,
	output csPair_t                     o_csAcc
);

	localparam int IdxW = $clog2(NumOps);

	data_t bank [NumOps];		// operand registers

	logic            ackQ;
	data_t           rdDat;
	logic            cmdHit;	// accepted ctrl write, ack cycle
	logic            startQ;
	logic [CntW-1:0] countQ;
	csPair_t         csAcc;
	data_t           result;

	logic            reqNew;	// cyc & stb not yet answered
	logic            opAdr;		// address inside operand bank
	logic            ctrlWr;
	logic [CntW-1:0] wrCount;
	logic [CntW-1:0] clamped;

	assign reqNew  = i_wbReq.cyc && i_wbReq.stb && !ackQ;
	assign opAdr   = i_wbReq.adr < AddrW'(NumOps);
	assign ctrlWr  = reqNew && i_wbReq.we && (i_wbReq.adr == AdrCtrl) && !i_busy;
	assign wrCount = i_wbReq.dat[CntW-1:0];
	assign clamped = (wrCount > CntW'(NumOps)) ? CntW'(NumOps) : wrCount;

	// ack one cycle after the request, start one cycle after ack
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			ackQ   <= 1'b0;
			cmdHit <= 1'b0;
			startQ <= 1'b0;
		end else begin
			ackQ   <= reqNew;
			cmdHit <= ctrlWr;		// busy writes still get ack, no start
			startQ <= cmdHit;
		end
	end

	always_ff @(posedge i_clk) begin
		if (ctrlWr)
			countQ <= clamped;
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			for (int i = 0; i < NumOps; i++)
				bank[i] <= '0;
		end else if (reqNew && i_wbReq.we && opAdr) begin
			bank[i_wbReq.adr[IdxW-1:0]] <= i_wbReq.dat;
		end
	end

	// read data registered alongside ack
	always_ff @(posedge i_clk) begin
		if (reqNew) begin
			if (opAdr)
				rdDat <= bank[i_wbReq.adr[IdxW-1:0]];
			else if (i_wbReq.adr == AdrStatus)
				rdDat <= {{(DataW-1){1'b0}}, i_busy};
			else if (i_wbReq.adr == AdrResult)
				rdDat <= result;
			else
				rdDat <= '0;		// ctrl and holes read zero
		end
	end

	// carry-save accumulator, cleared by the start pulse
	always_ff @(posedge i_clk) begin
		if (startQ)
			csAcc <= '0;
		else if (i_accumulate)
			csAcc <= i_csNext;
	end

	always_ff @(posedge i_clk) begin
		if (i_rst)
			result <= '0;
		else if (i_capture)
			result <= i_sum;
	end

	// pair at the pointer, upper word masked past the count
	assign o_opLo = bank[i_opIdx];
	assign o_opHi = i_hiValid ? bank[i_opIdx + IdxW'(1)] : '0;

	assign o_wbRsp = '{ack: ackQ, dat: rdDat};
	assign o_start = startQ;
	assign o_count = countQ;
	assign o_csAcc = csAcc;

endmodule

/* hw/lookaheadAdder.sv */
`timescale 1ns/1ns

module lookaheadAdder import adderPkg::*; (
	input  data_t i_a,
	input  data_t i_b,
	output data_t o_sum		// modulo 2^DataW
);

	localparam int NumBlk = DataW / 4;

	logic [NumBlk-1:0] blkC;	// carry into each 4-bit block

	assign blkC[0] = 1'b0;

	genvar b;
	generate
		for (b = 0; b < NumBlk; b = b + 1) begin : gBlk
			logic [3:0] p;		// propagate, a ^ b
			logic [3:0] g;		// generate, a & b
			logic [3:0] c;		// carry into each bit of the block

			assign p = i_a[4*b +: 4] ^ i_b[4*b +: 4];
			assign g = i_a[4*b +: 4] & i_b[4*b +: 4];

			// carries expanded straight from the block carry-in
			assign c[0] = blkC[b];
			assign c[1] = g[0] | (p[0] & c[0]);
			assign c[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & c[0]);
			assign c[3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0])
				| (p[2] & p[1] & p[0] & c[0]);

			assign o_sum[4*b +: 4] = p ^ c;

			// chain to the next block, carry out of the word is dropped
			if (b < NumBlk - 1) begin : gChain
				assign blkC[b+1] = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1])
					| (p[3] & p[2] & p[1] & g[0])
					| (p[3] & p[2] & p[1] & p[0] & c[0]);
			end
		end
	endgenerate

endmodule

/* hw/compressRow.sv */
`timescale 1ns/1ns

module compressRow import adderPkg::*; (
	input  csPair_t i_acc,		// running carry-save pair
	input  data_t   i_opLo,		// first operand of the step
	input  data_t   i_opHi,		// second operand, zero past the count
	output csPair_t o_next
);

	logic [DataW-2:0] coMid;		// horizontal carry, bit i into bit i+1
	logic [DataW-2:0] carryBit;		// vertical carry before the shift

	genvar i;
	generate
		for (i = 0; i < DataW; i = i + 1) begin : gCell
			logic x0, x1, x2, x3;
			logic ci;
			logic xor01, xor23, xor0123;

			assign x0 = i_acc.sum[i];
			assign x1 = i_acc.carry[i];
			assign x2 = i_opLo[i];
			assign x3 = i_opHi[i];
			assign ci = (i == 0) ? 1'b0 : coMid[(i == 0) ? 0 : i - 1];	// lowest cell gets 0

			assign xor01   = x0 ^ x1;
			assign xor23   = x2 ^ x3;
			assign xor0123 = xor01 ^ xor23;

			assign o_next.sum[i] = xor0123 ^ ci;

			// the top cell would only carry out of the word, so it stops at the sum
			if (i < DataW - 1) begin : gCarry
				assign coMid[i]    = xor01 ? x2 : x0;		// mux form, independent of ci
				assign carryBit[i] = xor0123 ? ci : x3;
			end
		end
	endgenerate

	// carry weighs twice the sum bit, top bit falls off
	assign o_next.carry = {carryBit, 1'b0};

endmodule

/* hw/adderPkg.sv */
package adderPkg;

	// datapath width, result wraps modulo 2^DataW
	localparam int DataW = 32;
	localparam int AddrW = 4;		// wishbone word address
	localparam int CntW  = 4;		// count field of the ctrl word

	// register map, operands sit at 0 .. NumOps-1
	localparam logic [AddrW-1:0] AdrCtrl   = 4'd8;	// write only, count + go
	localparam logic [AddrW-1:0] AdrStatus = 4'd9;	// bit 0 busy
	localparam logic [AddrW-1:0] AdrResult = 4'd10;	// last sum

	typedef logic [DataW-1:0] data_t;

	// host side of a classic cycle
	typedef struct packed {
		logic             cyc;
		logic             stb;
		logic             we;
		logic [AddrW-1:0] adr;
		data_t            dat;	// write data
	} wbReq_t;

	typedef struct packed {
		logic  ack;
		data_t dat;			// read data, valid with ack
	} wbRsp_t;

	// redundant form, value = sum + carry
	typedef struct packed {
		data_t sum;
		data_t carry;
	} csPair_t;

endpackage
